// File: source/apb_subsys_pkg.sv
/*
  shared widths, slot map and timer register offsets
  enums for timer registers, bridge sequencer states and bus responses
*/
`default_nettype none

package apb_subsys_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // slot field is haddr[15:12]
  localparam int SLOT_LSB      = 12;
  localparam int SLOT_TIMER    = 0;
  localparam int SLOT_STIMER   = 1;
  localparam int SLOT_NMI_WAKE = 2;
  localparam int SLOT_INTC     = 3;
  // slots at or above this are unmapped
  localparam int NUM_SLOTS     = 4;

  // channel picked by paddr[4]
  localparam int TIMER_CHANNELS = 2;

  // pending vector: [1:0] general timer, [3:2] system timer
  localparam int NUM_IRQ = 4;

  // timer register word offsets, paddr[3:2]
  typedef enum logic [1:0] {
    REG_LOAD   = 2'd0,
    REG_VALUE  = 2'd1,
    REG_CTRL   = 2'd2,
    REG_STATUS = 2'd3
  } timer_reg_t;

  // bridge sequencer
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } bridge_state_t;

  // host response codes
  typedef enum logic [1:0] {
    RESP_OKAY  = 2'b00,
    RESP_ERROR = 2'b01
  } hresp_t;

endpackage

`default_nettype wire

// File: source/apb_bridge.sv
/*
  single-transfer host to APB bridge
  slot decode, setup/enable sequencer, read data and response latch
*/
`timescale 1ns/1ps
`default_nettype none

module apb_bridge import apb_subsys_pkg::*; (
  input  wire logic                               per_clk,
  input  wire logic                               i_reset,
  input  wire logic                               i_hsel,
  input  wire logic [ADDR_W-1:0]                  i_haddr,
  input  wire logic                               i_hwrite,
  input  wire logic [DATA_W-1:0]                  i_hwdata,
  input  wire logic [NUM_SLOTS-1:0][DATA_W-1:0]   i_prdata,
  output logic      [DATA_W-1:0]                  o_hrdata,
  output logic                                    o_hready,
  output hresp_t                                  o_hresp,
  output logic      [ADDR_W-1:0]                  o_paddr,
  output logic                                    o_pwrite,
  output logic      [DATA_W-1:0]                  o_pwdata,
  output logic                                    o_penable,
  output logic      [NUM_SLOTS-1:0]               o_psel
);

  bridge_state_t        state_q;
  logic [3:0]           slot;
  logic                 slot_ok;
  logic                 slot_ok_q;
  logic [NUM_SLOTS-1:0] psel_dec;
  logic [DATA_W-1:0]    rdata_sel;
  logic                 take;

  // slot field of the incoming address
  assign slot    = i_haddr[SLOT_LSB +: 4];
  assign slot_ok = (slot < 4'(NUM_SLOTS));
  // one-hot select, none for an unmapped slot
  assign psel_dec = slot_ok ? (NUM_SLOTS'(1) << slot) : '0;

  // host may only strobe while idle
  assign o_hready = (state_q == ST_IDLE);
  assign take     = i_hsel && o_hready;

  // at most one psel is high, so an OR of masked words is the mux
  always_comb begin
    rdata_sel = '0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      rdata_sel |= i_prdata[s] & {DATA_W{o_psel[s]}};
    end
  end

  // sequencer and select lines
  always_ff @(posedge per_clk) begin
    if (i_reset) begin
      state_q   <= ST_IDLE;
      o_psel    <= '0;
      o_penable <= 1'b0;
      slot_ok_q <= 1'b0;
      o_hresp   <= RESP_OKAY;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (take) begin
            state_q   <= ST_SETUP;
            o_psel    <= psel_dec;
            slot_ok_q <= slot_ok;
          end
        end
        ST_SETUP: begin
          state_q   <= ST_ACCESS;
          // no enable phase for an unmapped slot
          o_penable <= slot_ok_q;
        end
        ST_ACCESS: begin
          state_q   <= ST_IDLE;
          o_penable <= 1'b0;
          o_psel    <= '0;
          o_hresp   <= slot_ok_q ? RESP_OKAY : RESP_ERROR;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // transfer payload, held for setup and enable
  always_ff @(posedge per_clk) begin
    if (take) begin
      o_paddr  <= i_haddr;
      o_pwrite <= i_hwrite;
      o_pwdata <= i_hwdata;
    end
    // read data sampled at the end of the enable cycle
    if (state_q == ST_ACCESS) begin
      o_hrdata <= o_pwrite ? '0 : rdata_sel;
    end
  end

  // host must not strobe while a transfer is in flight
  a_no_hsel_busy: assert property (@(posedge per_clk) disable iff (i_reset)
    i_hsel |-> o_hready);

  // enable phase always targets exactly one peripheral
  a_penable_onehot: assert property (@(posedge per_clk) disable iff (i_reset)
    o_penable |-> $onehot(o_psel));

  // unmapped access raises nothing on the peripheral side
  a_unmapped_quiet: assert property (@(posedge per_clk) disable iff (i_reset)
    (state_q != ST_IDLE && !slot_ok_q) |-> (o_psel == '0 && !o_penable));

endmodule

`default_nettype wire

// File: source/apb_timer.sv
/*
  two-channel reloading down-counter with APB register file
  load, value, control and sticky expired flag per channel
*/
`timescale 1ns/1ps
`default_nettype none

module apb_timer import apb_subsys_pkg::*; (
  input  wire logic                      per_clk,
  input  wire logic                      i_reset,
  input  wire logic                      i_psel,
  input  wire logic                      i_penable,
  input  wire logic                      i_pwrite,
  input  wire logic [ADDR_W-1:0]         i_paddr,
  input  wire logic [DATA_W-1:0]         i_pwdata,
  output logic      [DATA_W-1:0]         o_prdata,
  output logic      [TIMER_CHANNELS-1:0] o_irq
);

  logic [DATA_W-1:0]         load_q  [TIMER_CHANNELS];
  logic [DATA_W-1:0]         count_q [TIMER_CHANNELS];
  logic [TIMER_CHANNELS-1:0] en_q;
  logic [TIMER_CHANNELS-1:0] expired_q;
  logic [TIMER_CHANNELS-1:0] expire_now;
  logic                      wr_en;
  logic                      ch_sel;
  timer_reg_t                reg_sel;

  // paddr[4] picks the channel, [3:2] the register
  assign ch_sel  = i_paddr[4];
  assign reg_sel = timer_reg_t'(i_paddr[3:2]);
  // commit on the enable phase
  assign wr_en   = i_psel && i_penable && i_pwrite;

  // channel hits zero while running
  always_comb begin
    for (int c = 0; c < TIMER_CHANNELS; c++) begin
      expire_now[c] = en_q[c] && (count_q[c] == '0);
    end
  end

  always_ff @(posedge per_clk) begin
    if (i_reset) begin
      for (int c = 0; c < TIMER_CHANNELS; c++) begin
        load_q[c]  <= '0;
        count_q[c] <= '0;
      end
      en_q      <= '0;
      expired_q <= '0;
    end else begin
      for (int c = 0; c < TIMER_CHANNELS; c++) begin
        // count down, reload and flag one cycle after zero
        if (expire_now[c]) begin
          count_q[c]   <= load_q[c];
          expired_q[c] <= 1'b1;
        end else if (en_q[c]) begin
          count_q[c] <= count_q[c] - 1'b1;
        end
        // register writes, load also restarts the count
        if (wr_en && (ch_sel == 1'(c))) begin
          case (reg_sel)
            REG_LOAD: begin
              load_q[c]  <= i_pwdata;
              count_q[c] <= i_pwdata;
            end
            REG_CTRL: begin
              en_q[c] <= i_pwdata[0];
            end
            REG_STATUS: begin
              // write one to clear, a fresh expiry wins
              if (i_pwdata[0] && !expire_now[c]) begin
                expired_q[c] <= 1'b0;
              end
            end
            default: begin
            end
          endcase
        end
      end
    end
  end

  // zero wait-state read of the addressed register
  always_comb begin
    o_prdata = '0;
    case (reg_sel)
      REG_LOAD:   o_prdata = load_q[ch_sel];
      REG_VALUE:  o_prdata = count_q[ch_sel];
      REG_CTRL:   o_prdata[0] = en_q[ch_sel];
      REG_STATUS: o_prdata[0] = expired_q[ch_sel];
      default:    o_prdata = '0;
    endcase
  end

  // interrupt level follows the flag
  assign o_irq = expired_q;

  for (genvar g = 0; g < TIMER_CHANNELS; g++) begin : g_chk
    // flag only rises the cycle after a running channel sat at zero
    a_flag_rise: assert property (@(posedge per_clk) disable iff (i_reset)
      $rose(expired_q[g]) |-> $past(en_q[g] && (count_q[g] == '0)));
  end

endmodule

`default_nettype wire

// File: source/int_collector.sv
/*
  rising edge detect into a write-one-to-clear pending vector
*/
`timescale 1ns/1ps
`default_nettype none

module int_collector import apb_subsys_pkg::*; (
  input  wire logic               per_clk,
  input  wire logic               i_reset,
  input  wire logic               i_psel,
  input  wire logic               i_penable,
  input  wire logic               i_pwrite,
  input  wire logic [DATA_W-1:0]  i_pwdata,
  input  wire logic [NUM_IRQ-1:0] i_irq,
  output logic      [DATA_W-1:0]  o_prdata,
  output logic      [NUM_IRQ-1:0] o_int_vld,
  output logic                    o_intraw_vld
);

  logic [NUM_IRQ-1:0] irq_prev_q;
  logic [NUM_IRQ-1:0] pend_q;
  logic [NUM_IRQ-1:0] rise;
  logic [NUM_IRQ-1:0] clr_mask;

  // low last cycle, high now
  assign rise = i_irq & ~irq_prev_q;

  // ones in the write data clear
  assign clr_mask = (i_psel && i_penable && i_pwrite) ? i_pwdata[NUM_IRQ-1:0] : '0;

  always_ff @(posedge per_clk) begin
    if (i_reset) begin
      irq_prev_q <= '0;
      pend_q     <= '0;
    end else begin
      irq_prev_q <= i_irq;
      // set after clear, so a same-cycle edge survives
      pend_q     <= (pend_q & ~clr_mask) | rise;
    end
  end

  // read back pending bits
  assign o_prdata     = {{(DATA_W-NUM_IRQ){1'b0}}, pend_q};
  assign o_int_vld    = pend_q;
  assign o_intraw_vld = |pend_q;

endmodule

`default_nettype wire

// File: source/apb_subsys_top.sv
/*
  peripheral subsystem top
  bridge, general/system/NMI-wake timers and interrupt collector
*/
`timescale 1ns/1ps
`default_nettype none

module apb_subsys_top import apb_subsys_pkg::*; (
  input  wire logic               per_clk,
  input  wire logic               i_reset,
  input  wire logic               i_hsel,
  input  wire logic [ADDR_W-1:0]  i_haddr,
  input  wire logic               i_hwrite,
  input  wire logic [DATA_W-1:0]  i_hwdata,
  output logic      [DATA_W-1:0]  o_hrdata,
  output logic                    o_hready,
  output hresp_t                  o_hresp,
  output logic      [NUM_IRQ-1:0] o_int_vld,
  output logic                    o_intraw_vld,
  output logic                    o_nmi_req,
  output logic                    o_wakeup_req
);

  // shared APB nets
  logic [ADDR_W-1:0]                paddr;
  logic                             pwrite;
  logic [DATA_W-1:0]                pwdata;
  logic                             penable;
  logic [NUM_SLOTS-1:0]             psel;
  logic [NUM_SLOTS-1:0][DATA_W-1:0] prdata;

  // timer interrupt levels
  logic [TIMER_CHANNELS-1:0] tim_irq;
  logic [TIMER_CHANNELS-1:0] stim_irq;
  logic [TIMER_CHANNELS-1:0] nmi_wake_irq;

  apb_bridge u_bridge (
    .per_clk   (per_clk),
    .i_reset   (i_reset),
    .i_hsel    (i_hsel),
    .i_haddr   (i_haddr),
    .i_hwrite  (i_hwrite),
    .i_hwdata  (i_hwdata),
    .i_prdata  (prdata),
    .o_hrdata  (o_hrdata),
    .o_hready  (o_hready),
    .o_hresp   (o_hresp),
    .o_paddr   (paddr),
    .o_pwrite  (pwrite),
    .o_pwdata  (pwdata),
    .o_penable (penable),
    .o_psel    (psel)
  );

  apb_timer u_timer (
    .per_clk   (per_clk),
    .i_reset   (i_reset),
    .i_psel    (psel[SLOT_TIMER]),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata[SLOT_TIMER]),
    .o_irq     (tim_irq)
  );

  apb_timer u_stimer (
    .per_clk   (per_clk),
    .i_reset   (i_reset),
    .i_psel    (psel[SLOT_STIMER]),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata[SLOT_STIMER]),
    .o_irq     (stim_irq)
  );

  apb_timer u_nmi_wake (
    .per_clk   (per_clk),
    .i_reset   (i_reset),
    .i_psel    (psel[SLOT_NMI_WAKE]),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata[SLOT_NMI_WAKE]),
    .o_irq     (nmi_wake_irq)
  );

  // general timer on [1:0], system timer on [3:2]
  int_collector u_intc (
    .per_clk      (per_clk),
    .i_reset      (i_reset),
    .i_psel       (psel[SLOT_INTC]),
    .i_penable    (penable),
    .i_pwrite     (pwrite),
    .i_pwdata     (pwdata),
    .i_irq        ({stim_irq, tim_irq}),
    .o_prdata     (prdata[SLOT_INTC]),
    .o_int_vld    (o_int_vld),
    .o_intraw_vld (o_intraw_vld)
  );

  // NMI on channel 0, wake on channel 1
  assign o_nmi_req    = nmi_wake_irq[0];
  assign o_wakeup_req = nmi_wake_irq[1];

endmodule

`default_nettype wire

// File: verification/tb_apb_subsys.sv
/*
  testbench for the peripheral subsystem top
  clock, reset, transaction table, row runner and result lines
*/
`timescale 1ns/1ps
`default_nettype none

module tb_apb_subsys import apb_subsys_pkg::*; ();

  // bit positions in out_bits
  localparam int BIT_INTRAW   = 4;
  localparam int BIT_NMI      = 5;
  localparam int BIT_WAKE     = 6;
  localparam int XFER_BOUND   = 8;
  localparam int EXPIRY_BOUND = 400;

  typedef enum {WRITE, READ, WAIT_IRQ} row_kind_t;

  // WAIT_IRQ rows: addr holds the bit index, wdata[0] the level to wait for
  typedef struct {
    row_kind_t         kind;
    int                test;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp_rdata;
    hresp_t            exp_resp;
    int                bound;
  } row_t;

  logic               per_clk;
  logic               i_reset;
  logic               i_hsel;
  logic [ADDR_W-1:0]  i_haddr;
  logic               i_hwrite;
  logic [DATA_W-1:0]  i_hwdata;
  logic [DATA_W-1:0]  o_hrdata;
  logic               o_hready;
  hresp_t             o_hresp;
  logic [NUM_IRQ-1:0] o_int_vld;
  logic               o_intraw_vld;
  logic               o_nmi_req;
  logic               o_wakeup_req;
  logic [6:0]         out_bits;

  row_t              rows[$];
  logic [31:0]       rng_state;
  logic [DATA_W-1:0] loads [3][2];
  int                err_count;
  int                test_err_start;
  int                tests_passed;
  int                tests_failed;

  apb_subsys_top DUT (
    .per_clk      (per_clk),
    .i_reset      (i_reset),
    .i_hsel       (i_hsel),
    .i_haddr      (i_haddr),
    .i_hwrite     (i_hwrite),
    .i_hwdata     (i_hwdata),
    .o_hrdata     (o_hrdata),
    .o_hready     (o_hready),
    .o_hresp      (o_hresp),
    .o_int_vld    (o_int_vld),
    .o_intraw_vld (o_intraw_vld),
    .o_nmi_req    (o_nmi_req),
    .o_wakeup_req (o_wakeup_req)
  );

  // all watched outputs in one vector
  assign out_bits = {o_wakeup_req, o_nmi_req, o_intraw_vld, o_int_vld};

  // 40 ns period
  initial begin
    per_clk = 1'b0;
    forever #20 per_clk = ~per_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // slot, channel and register word to a bus address
  function automatic logic [ADDR_W-1:0] reg_addr(input int slot, input int ch,
                                                 input timer_reg_t r);
    return (32'(slot) << SLOT_LSB) | (32'(ch) << 4) | (32'(r) << 2);
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1:       return "after reset";
      2:       return "slot isolation";
      3:       return "unmapped slot";
      4:       return "expiry and clearing";
      5:       return "nmi and wake mapping";
      default: return "pending persists";
    endcase
  endfunction

  task automatic check_value(input logic [31:0] exp, input logic [31:0] act,
                             input string what);
    if (exp !== act) begin
      $display("ERROR at %0t ns: %s expected %h got %h", $time, what, exp, act);
      err_count++;
    end
  endtask

  task automatic add_row(input row_kind_t kind, input int test, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [31:0] exp_rdata,
                         input hresp_t exp_resp, input int bound);
    row_t r;
    r.kind      = kind;
    r.test      = test;
    r.addr      = addr;
    r.wdata     = wdata;
    r.exp_rdata = exp_rdata;
    r.exp_resp  = exp_resp;
    r.bound     = bound;
    rows.push_back(r);
  endtask

  task automatic write_row(input int t, input logic [31:0] a, input logic [31:0] d,
                           input hresp_t resp);
    add_row(WRITE, t, a, d, '0, resp, XFER_BOUND);
  endtask

  task automatic read_row(input int t, input logic [31:0] a, input logic [31:0] exp,
                          input hresp_t resp);
    add_row(READ, t, a, '0, exp, resp, XFER_BOUND);
  endtask

  // bound 0 checks the level right away
  task automatic wait_row(input int t, input int bit_idx, input logic level, input int bound);
    add_row(WAIT_IRQ, t, 32'(bit_idx), 32'(level), '0, RESP_OKAY, bound);
  endtask

  task automatic build_table();
    logic [255:0] taken;
    logic [31:0]  cand;
    taken = '0;
    // distinct nonzero 8-bit loads
    for (int t = 0; t < 3; t++) begin
      for (int c = 0; c < 2; c++) begin
        do begin
          rng_state = xorshift32(rng_state);
          cand      = rng_state & 32'hff;
        end while (cand == 0 || taken[cand[7:0]]);
        taken[cand[7:0]] = 1'b1;
        loads[t][c]      = cand;
      end
    end
    for (int b = 0; b < 7; b++) wait_row(1, b, 1'b0, 0);
    for (int t = 0; t < 3; t++) begin
      for (int c = 0; c < 2; c++) read_row(1, reg_addr(t, c, REG_VALUE), 0, RESP_OKAY);
    end
    for (int t = 0; t < 3; t++) begin
      for (int c = 0; c < 2; c++) write_row(2, reg_addr(t, c, REG_LOAD), loads[t][c], RESP_OKAY);
    end
    for (int t = 0; t < 3; t++) begin
      for (int c = 0; c < 2; c++) read_row(2, reg_addr(t, c, REG_LOAD), loads[t][c], RESP_OKAY);
    end
    // slot 5 is outside the map
    write_row(3, reg_addr(5, 0, REG_LOAD), 32'hdead_beef, RESP_ERROR);
    read_row(3, reg_addr(5, 0, REG_LOAD), 0, RESP_ERROR);
    // every mapped load still holds its own value
    for (int t = 0; t < 3; t++) begin
      for (int c = 0; c < 2; c++) read_row(3, reg_addr(t, c, REG_LOAD), loads[t][c], RESP_OKAY);
    end
    // general timer ch1, small load, stop it before clearing
    write_row(4, reg_addr(SLOT_TIMER, 1, REG_LOAD), 12, RESP_OKAY);
    write_row(4, reg_addr(SLOT_TIMER, 1, REG_CTRL), 1, RESP_OKAY);
    wait_row(4, 1, 1'b1, EXPIRY_BOUND);
    wait_row(4, BIT_INTRAW, 1'b1, 0);
    write_row(4, reg_addr(SLOT_TIMER, 1, REG_CTRL), 0, RESP_OKAY);
    read_row(4, reg_addr(SLOT_TIMER, 1, REG_STATUS), 1, RESP_OKAY);
    write_row(4, reg_addr(SLOT_INTC, 0, REG_LOAD), 2, RESP_OKAY);
    wait_row(4, 1, 1'b0, 0);
    wait_row(4, BIT_INTRAW, 1'b0, 0);
    write_row(4, reg_addr(SLOT_TIMER, 1, REG_STATUS), 1, RESP_OKAY);
    read_row(4, reg_addr(SLOT_TIMER, 1, REG_STATUS), 0, RESP_OKAY);
    // nmi on ch0, wake on ch1
    write_row(5, reg_addr(SLOT_NMI_WAKE, 0, REG_CTRL), 1, RESP_OKAY);
    wait_row(5, BIT_NMI, 1'b1, EXPIRY_BOUND);
    wait_row(5, BIT_WAKE, 1'b0, 0);
    write_row(5, reg_addr(SLOT_NMI_WAKE, 1, REG_CTRL), 1, RESP_OKAY);
    wait_row(5, BIT_WAKE, 1'b1, EXPIRY_BOUND);
    write_row(5, reg_addr(SLOT_NMI_WAKE, 0, REG_CTRL), 0, RESP_OKAY);
    write_row(5, reg_addr(SLOT_NMI_WAKE, 1, REG_CTRL), 0, RESP_OKAY);
    write_row(5, reg_addr(SLOT_NMI_WAKE, 0, REG_STATUS), 1, RESP_OKAY);
    wait_row(5, BIT_NMI, 1'b0, 0);
    wait_row(5, BIT_WAKE, 1'b1, 0);
    write_row(5, reg_addr(SLOT_NMI_WAKE, 1, REG_STATUS), 1, RESP_OKAY);
    wait_row(5, BIT_WAKE, 1'b0, 0);
    // system timer ch0 lands on pending bit 2
    write_row(6, reg_addr(SLOT_STIMER, 0, REG_CTRL), 1, RESP_OKAY);
    wait_row(6, 2, 1'b1, EXPIRY_BOUND);
    write_row(6, reg_addr(SLOT_STIMER, 0, REG_CTRL), 0, RESP_OKAY);
    write_row(6, reg_addr(SLOT_STIMER, 0, REG_STATUS), 1, RESP_OKAY);
    read_row(6, reg_addr(SLOT_STIMER, 0, REG_STATUS), 0, RESP_OKAY);
    wait_row(6, 2, 1'b1, 0);
    read_row(6, reg_addr(SLOT_INTC, 0, REG_LOAD), 32'h4, RESP_OKAY);
    write_row(6, reg_addr(SLOT_INTC, 0, REG_LOAD), 4, RESP_OKAY);
    wait_row(6, 2, 1'b0, 0);
    wait_row(6, BIT_INTRAW, 1'b0, 0);
  endtask

  task automatic run_row(input row_t r);
    int waited;
    waited = 0;
    if (r.kind == WAIT_IRQ) begin
      while (out_bits[r.addr[2:0]] !== r.wdata[0] && waited < r.bound) begin
        @(posedge per_clk);
        #2;
        waited++;
      end
      if (r.bound == 0) begin
        check_value(32'(r.wdata[0]), 32'(out_bits[r.addr[2:0]]),
                    $sformatf("output bit %0d", r.addr));
      end else if (out_bits[r.addr[2:0]] !== r.wdata[0]) begin
        $display("timeout: output bit %0d never reached %0b within %0d cycles",
                 r.addr, r.wdata[0], r.bound);
        err_count++;
      end
    end else begin
      while (!o_hready && waited < r.bound) begin
        @(posedge per_clk);
        #2;
        waited++;
      end
      if (!o_hready) begin
        $display("timeout: bus still busy before the transfer to %h", r.addr);
        err_count++;
      end else begin
        // one-cycle strobe
        i_hsel   = 1'b1;
        i_haddr  = r.addr;
        i_hwrite = (r.kind == WRITE);
        i_hwdata = r.wdata;
        @(posedge per_clk);
        #2;
        i_hsel = 1'b0;
        waited = 0;
        while (!o_hready && waited < r.bound) begin
          @(posedge per_clk);
          #2;
          waited++;
        end
        if (!o_hready) begin
          $display("timeout: no response to the transfer at %h", r.addr);
          err_count++;
        end else begin
          check_value(2, 32'(waited), $sformatf("latency at %h", r.addr));
          check_value(32'(r.exp_resp), 32'(o_hresp), $sformatf("response at %h", r.addr));
          // error responses carry zero data for writes too
          if (r.kind == READ || r.exp_resp == RESP_ERROR) begin
            check_value(r.exp_rdata, o_hrdata, $sformatf("read data at %h", r.addr));
          end
        end
      end
    end
  endtask

  task automatic finish_test(input int t);
    if (err_count == test_err_start) begin
      $display("test %0d (%s) passed", t, test_name(t));
      tests_passed++;
    end else begin
      $display("test %0d (%s) failed", t, test_name(t));
      tests_failed++;
    end
    test_err_start = err_count;
  endtask

  initial begin
    int cur_test;
    i_reset        = 1'b1;
    i_hsel         = 1'b0;
    i_haddr        = '0;
    i_hwrite       = 1'b0;
    i_hwdata       = '0;
    err_count      = 0;
    test_err_start = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    rng_state      = 32'd61830;
    build_table();
    repeat (16) @(posedge per_clk);
    #2;
    i_reset = 1'b0;
    check_value(1, 32'(o_hready), "hready after reset");
    cur_test = rows[0].test;
    foreach (rows[i]) begin
      if (rows[i].test != cur_test) begin
        finish_test(cur_test);
        cur_test = rows[i].test;
      end
      run_row(rows[i]);
    end
    finish_test(cur_test);
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
source/apb_subsys_pkg.sv
source/apb_bridge.sv
source/apb_timer.sv
source/int_collector.sv
source/apb_subsys_top.sv
verification/tb_apb_subsys.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_apb_subsys \
    -Mdir obj_dir -o tb_apb_subsys > build.log 2>&1 \
  && ./obj_dir/tb_apb_subsys > sim.log 2>&1 ; cat sim.log 2>/dev/null \
  ; grep -q "^TEST RESULT: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
